// ==== Makefile ====
TOP = tb_sigmoid_uart

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard src/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module sigmoid_uart_top \
		src/sigmoid_pkg.sv src/uart_rx.sv src/uart_tx.sv \
		src/frame_decoder.sv src/sigmoid_pwl.sv \
		src/result_serializer.sv src/sigmoid_uart_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
src/sigmoid_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/frame_decoder.sv
src/sigmoid_pwl.sv
src/result_serializer.sv
src/sigmoid_uart_top.sv
verification/sigmoid_uart_checker.sv
verification/tb_sigmoid_uart.sv

// ==== src/frame_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_decoder
	import sigmoid_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [7:0]           rx_byte,
	input  logic                 rx_done,
	output logic [OPERAND_W-1:0] operand,
	output logic                 operand_valid
);

	localparam int CNT_W = (IN_BYTES > 2) ? $clog2(IN_BYTES) : 1;
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(IN_BYTES - 1);

	decode_state_t state;
	// bytes taken so far in this frame
	logic [CNT_W-1:0] byte_count;

	// operand register is payload and shifts in at the low end
	always_ff @(posedge clk) begin
		if (rx_done)
			operand <= {operand[OPERAND_W-9:0], rx_byte};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dec_waiting;
			byte_count <= '0;
			operand_valid <= 1'b0;
		end else begin
			operand_valid <= 1'b0;
			case (state)
				dec_waiting: begin
					if (rx_done) begin
						byte_count <= CNT_W'(1);
						state <= dec_assembling;
					end
				end
				dec_assembling: begin
					if (rx_done) begin
						if (byte_count == LAST_BYTE) begin
							// full operand now in place
							operand_valid <= 1'b1;
							byte_count <= '0;
							state <= dec_waiting;
						end else begin
							byte_count <= byte_count + 1'b1;
						end
					end
				end
				default: state <= dec_waiting;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/result_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_serializer
	import sigmoid_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic [RESULT_W-1:0] result,
	input  logic                result_valid,
	input  logic                tx_busy,
	output logic [7:0]          tx_byte,
	output logic                tx_start,
	output logic                overrun
);

	localparam int CNT_W = $clog2(OUT_BYTES);
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(OUT_BYTES - 1);

	result_state_t state;
	logic [RESULT_W-1:0] result_q;
	logic [CNT_W-1:0] byte_count;

	// lsb first
	assign tx_byte = result_q[{byte_count, 3'b000} +: 8];

	// start only while the transmitter is free
	assign tx_start = (state == res_load) && !tx_busy;

	// holding register for one result
	always_ff @(posedge clk) begin
		if (state == res_idle && result_valid)
			result_q <= result;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= res_idle;
			byte_count <= '0;
		end else begin
			case (state)
				res_idle: begin
					byte_count <= '0;
					if (result_valid)
						state <= res_load;
				end
				res_load: begin
					if (!tx_busy)
						state <= res_wait_busy;
				end
				res_wait_busy: begin
					// busy is already high the cycle after tx_start
					if (!tx_busy) begin
						if (byte_count == LAST_BYTE) begin
							state <= res_idle;
						end else begin
							byte_count <= byte_count + 1'b1;
							state <= res_load;
						end
					end
				end
				default: state <= res_idle;
			endcase
		end
	end

	// sticky until reset
	always_ff @(posedge clk) begin
		if (reset)
			overrun <= 1'b0;
		else if (result_valid && state != res_idle)
			overrun <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/sigmoid_pkg.sv ====
`default_nettype none

package sigmoid_pkg;

	// operand and result formats
	localparam int OPERAND_W = 16;
	localparam int OPERAND_FRAC = 11;
	localparam int RESULT_W = 24;
	localparam int RESULT_FRAC = 16;

	// bytes per frame on the serial line
	localparam int IN_BYTES = 2;
	localparam int OUT_BYTES = 3;

	// breakpoints in operand scale (Q5.11)
	localparam logic [OPERAND_W-1:0] SEG_SAT = OPERAND_W'(5 << OPERAND_FRAC);
	localparam logic [OPERAND_W-1:0] SEG_HI = OPERAND_W'(19 << (OPERAND_FRAC - 3));
	localparam logic [OPERAND_W-1:0] SEG_MID = OPERAND_W'(1 << OPERAND_FRAC);

	// offsets in result scale (Q8.16)
	localparam logic [RESULT_W-1:0] OFF_HI = RESULT_W'(27 << (RESULT_FRAC - 5));
	localparam logic [RESULT_W-1:0] OFF_MID = RESULT_W'(5 << (RESULT_FRAC - 3));
	localparam logic [RESULT_W-1:0] OFF_LO = RESULT_W'(1 << (RESULT_FRAC - 1));
	localparam logic [RESULT_W-1:0] ONE = RESULT_W'(1 << RESULT_FRAC);

	typedef enum logic {dec_waiting, dec_assembling} decode_state_t;

	// shared by receiver and transmitter
	typedef enum logic [1:0] {ser_idle, ser_start, ser_data, ser_stop} serial_state_t;

	typedef enum logic [1:0] {res_idle, res_load, res_wait_busy} result_state_t;

endpackage

`default_nettype wire

// ==== src/sigmoid_pwl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sigmoid_pwl
	import sigmoid_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [OPERAND_W-1:0] operand,
	input  logic                 operand_valid,
	output logic [RESULT_W-1:0]  result,
	output logic                 result_valid
);

	// shift from operand scale to result scale
	localparam int SCALE = RESULT_FRAC - OPERAND_FRAC;

	localparam logic [1:0] SEG_CODE_LO = 2'd0;
	localparam logic [1:0] SEG_CODE_MID = 2'd1;
	localparam logic [1:0] SEG_CODE_HI = 2'd2;
	localparam logic [1:0] SEG_CODE_SAT = 2'd3;

	logic [OPERAND_W-1:0] mag;
	logic [1:0] seg;
	logic [OPERAND_W-1:0] mag_q;
	logic [1:0] seg_q;
	logic sign_q;
	logic valid_q;
	logic [RESULT_W-1:0] mag_ext;
	logic [RESULT_W-1:0] pos_val;

	// magnitude as unsigned, so the most negative operand still fits
	assign mag = operand[OPERAND_W-1] ? (~operand + 1'b1) : operand;

	always_comb begin
		if (mag >= SEG_SAT)
			seg = SEG_CODE_SAT;
		else if (mag >= SEG_HI)
			seg = SEG_CODE_HI;
		else if (mag >= SEG_MID)
			seg = SEG_CODE_MID;
		else
			seg = SEG_CODE_LO;
	end

	// stage one
	always_ff @(posedge clk) begin
		mag_q <= mag;
		seg_q <= seg;
		sign_q <= operand[OPERAND_W-1];
	end

	assign mag_ext = RESULT_W'(mag_q);

	// slope is a power of two in every segment
	always_comb begin
		case (seg_q)
			SEG_CODE_LO: pos_val = (mag_ext << (SCALE - 2)) + OFF_LO;
			SEG_CODE_MID: pos_val = (mag_ext << (SCALE - 3)) + OFF_MID;
			SEG_CODE_HI: pos_val = (mag_ext << (SCALE - 5)) + OFF_HI;
			default: pos_val = ONE;
		endcase
	end

	// stage two
	always_ff @(posedge clk) begin
		result <= sign_q ? (ONE - pos_val) : pos_val;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			valid_q <= operand_valid;
			result_valid <= valid_q;
		end
	end

endmodule

`default_nettype wire

// ==== src/sigmoid_uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sigmoid_uart_top
	import sigmoid_pkg::*;
#(
	parameter int unsigned CLKS_PER_BIT = 32'd10416
) (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic overrun
);

	logic [7:0] rx_byte;
	logic rx_done;
	logic [OPERAND_W-1:0] operand;
	logic operand_valid;
	logic [RESULT_W-1:0] result;
	logic result_valid;
	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	// decode
	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_rx_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_byte(rx_byte),
		.rx_done(rx_done)
	);

	frame_decoder frame_decoder_i (
		.clk(clk),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_done(rx_done),
		.operand(operand),
		.operand_valid(operand_valid)
	);

	// execute
	sigmoid_pwl sigmoid_pwl_i (
		.clk(clk),
		.reset(reset),
		.operand(operand),
		.operand_valid(operand_valid),
		.result(result),
		.result_valid(result_valid)
	);

	// result
	result_serializer result_serializer_i (
		.clk(clk),
		.reset(reset),
		.result(result),
		.result_valid(result_valid),
		.tx_busy(tx_busy),
		.tx_byte(tx_byte),
		.tx_start(tx_start),
		.overrun(overrun)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_tx_i (
		.clk(clk),
		.reset(reset),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx(tx),
		.tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import sigmoid_pkg::*;
#(
	parameter int unsigned CLKS_PER_BIT = 32'd10416
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_done
);

	localparam logic [31:0] HALF_BIT = CLKS_PER_BIT / 2;

	serial_state_t state;
	logic [31:0] clk_count;
	logic [2:0] bit_index;
	logic [7:0] shift_reg;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;

	// two-flop synchronizer, plus one more for the edge
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ser_idle;
			clk_count <= '0;
			bit_index <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				ser_idle: begin
					clk_count <= '0;
					bit_index <= '0;
					// falling edge marks a start bit
					if (rx_prev && !rx_sync)
						state <= ser_start;
				end
				ser_start: begin
					if (clk_count == HALF_BIT - 1) begin
						clk_count <= '0;
						// glitch if the line is high again at mid-bit
						state <= rx_sync ? ser_idle : ser_data;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				ser_data: begin
					if (clk_count == CLKS_PER_BIT - 1) begin
						clk_count <= '0;
						shift_reg <= {rx_sync, shift_reg[7:1]};
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= ser_stop;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				ser_stop: begin
					if (clk_count == CLKS_PER_BIT - 1) begin
						clk_count <= '0;
						state <= ser_idle;
						// low stop bit drops the frame
						if (rx_sync) begin
							rx_done <= 1'b1;
							rx_byte <= shift_reg;
						end
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				default: state <= ser_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import sigmoid_pkg::*;
#(
	parameter int unsigned CLKS_PER_BIT = 32'd10416
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx,
	output logic       tx_busy
);

	serial_state_t state;
	logic [31:0] clk_count;
	logic [2:0] bit_index;
	logic [7:0] shift_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ser_idle;
			clk_count <= '0;
			bit_index <= '0;
			tx <= 1'b1;
			tx_busy <= 1'b0;
		end else begin
			case (state)
				ser_idle: begin
					clk_count <= '0;
					bit_index <= '0;
					tx <= 1'b1;
					if (tx_start) begin
						shift_reg <= tx_byte;
						tx <= 1'b0;
						tx_busy <= 1'b1;
						state <= ser_start;
					end
				end
				ser_start: begin
					if (clk_count == CLKS_PER_BIT - 1) begin
						clk_count <= '0;
						tx <= shift_reg[0];
						state <= ser_data;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				ser_data: begin
					if (clk_count == CLKS_PER_BIT - 1) begin
						clk_count <= '0;
						bit_index <= bit_index + 1'b1;
						// lsb first
						if (bit_index == 3'd7) begin
							tx <= 1'b1;
							state <= ser_stop;
						end else begin
							tx <= shift_reg[1];
							shift_reg <= {1'b0, shift_reg[7:1]};
						end
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				ser_stop: begin
					if (clk_count == CLKS_PER_BIT - 1) begin
						clk_count <= '0;
						tx_busy <= 1'b0;
						state <= ser_idle;
					end else begin
						clk_count <= clk_count + 1'b1;
					end
				end
				default: state <= ser_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verification/sigmoid_uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sigmoid_uart_checker
	import sigmoid_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic tx,
	input  logic overrun,
	input  logic allow_overrun,
	output int   replies,
	output int   errors,
	output int   pending
);

	// expected replies, in the order the frames were sent
	logic [OPERAND_W-1:0] op_q [$];
	logic [RESULT_W-1:0] exp_q [$];

	logic [RESULT_W-1:0] reply_word;
	logic [7:0] rx_bits;
	logic tx_q;
	bit overrun_seen;
	bit active;
	int cnt;
	int bit_pos;
	int byte_idx;
	int reply_cnt = 0;
	int err_cnt = 0;

	task automatic expect_value(input logic [OPERAND_W-1:0] op,
			input logic [RESULT_W-1:0] value);
		op_q.push_back(op);
		exp_q.push_back(value);
	endtask

	task automatic compare_reply();
		logic [OPERAND_W-1:0] op;
		logic [RESULT_W-1:0] exp;
		if (exp_q.size() == 0) begin
			$display("CHECK FAILED at %0t: reply %h arrived with no frame pending",
				$time, reply_word);
			err_cnt++;
		end else begin
			op = op_q.pop_front();
			exp = exp_q.pop_front();
			if (reply_word === exp) begin
				$display("reply %0d: operand %h gives %h ok", reply_cnt, op, reply_word);
			end else begin
				$display("CHECK FAILED at %0t: operand %h expected %h, got %h",
					$time, op, exp, reply_word);
				err_cnt++;
			end
		end
		reply_cnt++;
	endtask

	// tx deserializer, counting cycles from the start edge
	always @(posedge clk) begin
		if (reset) begin
			active = 0;
			tx_q = 1'b1;
			byte_idx = 0;
			overrun_seen = 0;
		end else begin
			if (active) begin
				cnt++;
				// mid-bit of start, eight data bits, then stop
				if (cnt == CLKS_PER_BIT / 2 + bit_pos * CLKS_PER_BIT) begin
					if (bit_pos == 0) begin
						if (tx !== 1'b0) begin
							$display("at %0t the tx start bit did not stay low", $time);
							err_cnt++;
							active = 0;
						end
					end else if (bit_pos <= 8) begin
						rx_bits = {tx, rx_bits[7:1]};
					end else begin
						active = 0;
						if (tx !== 1'b1) begin
							$display("at %0t a tx stop bit was low", $time);
							err_cnt++;
							byte_idx = 0;
						end else begin
							// first byte ends up least significant
							reply_word = {rx_bits, reply_word[RESULT_W-1:8]};
							byte_idx++;
							if (byte_idx == OUT_BYTES) begin
								compare_reply();
								byte_idx = 0;
							end
						end
					end
					bit_pos++;
				end
			end else if (tx_q && !tx) begin
				active = 1;
				cnt = 1;
				bit_pos = 0;
			end
			tx_q = tx;
			if (overrun && !allow_overrun && !overrun_seen) begin
				$display("CHECK FAILED at %0t: overrun went high with no overrun expected",
					$time);
				err_cnt++;
				overrun_seen = 1;
			end
		end
		replies <= reply_cnt;
		errors <= err_cnt;
		pending <= exp_q.size();
	end

endmodule

`default_nettype wire

// ==== verification/tb_sigmoid_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sigmoid_uart
	import sigmoid_pkg::*;
();

	localparam int CLKS_PER_BIT = 16;
	localparam int REPLY_TIMEOUT = 4000;
	localparam int NUM_RANDOM = 200;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic overrun;
	logic allow_overrun;
	int replies;
	int check_errors;
	int pending;
	int tb_errors;
	integer seed;

	sigmoid_uart_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) sigmoid_uart_top_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.overrun(overrun)
	);

	sigmoid_uart_checker #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) checker_i (
		.clk(clk),
		.reset(reset),
		.tx(tx),
		.overrun(overrun),
		.allow_overrun(allow_overrun),
		.replies(replies),
		.errors(check_errors),
		.pending(pending)
	);

	always #5 clk = ~clk;

	// operand in units of 2^-11, result in units of 2^-16
	function automatic logic [RESULT_W-1:0] sigmoid_ref(input logic [OPERAND_W-1:0] op);
		int a;
		int val;
		a = op[OPERAND_W-1] ? 65536 - int'(op) : int'(op);
		if (a >= 5 * 2048)
			val = 65536;
		else if (a >= (19 * 2048) / 8)
			val = (a * 32) / 32 + (27 * 65536) / 32;
		else if (a >= 2048)
			val = (a * 32) / 8 + (5 * 65536) / 8;
		else
			val = (a * 32) / 4 + 65536 / 2;
		if (op[OPERAND_W-1])
			val = 65536 - val;
		return RESULT_W'(val);
	endfunction

	function automatic int total_errors();
		return tb_errors + check_errors;
	endfunction

	task automatic drive_bit(input logic b);
		rx = b;
		repeat (CLKS_PER_BIT) @(posedge clk);
		#1;
	endtask

	task automatic send_byte(input logic [7:0] data, input logic stop);
		logic [7:0] d;
		d = data;
		drive_bit(1'b0);
		repeat (8) begin
			drive_bit(d[0]);
			d = d >> 1;
		end
		drive_bit(stop);
	endtask

	// expected value goes in only once the frame is on the line
	task automatic send_frame(input logic [OPERAND_W-1:0] op, input bit expect_reply);
		send_byte(op[15:8], 1'b1);
		send_byte(op[7:0], 1'b1);
		if (expect_reply)
			checker_i.expect_value(op, sigmoid_ref(op));
	endtask

	task automatic wait_replies(input int target, input logic [OPERAND_W-1:0] op);
		int cycles;
		cycles = 0;
		while (replies < target && cycles < REPLY_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (replies < target) begin
			$display("timeout at %0t: no reply came back for operand %h", $time, op);
			tb_errors++;
		end
	endtask

	task automatic run_frame(input logic [OPERAND_W-1:0] op);
		int base;
		base = replies;
		send_frame(op, 1'b1);
		wait_replies(base + 1, op);
	endtask

	task automatic watch_outputs(input int cycles, input int exp_replies,
			input logic exp_overrun, input bit tx_idle);
		bit reported;
		reported = 0;
		repeat (cycles) begin
			@(posedge clk);
			#1;
			if (!reported && (overrun !== exp_overrun || replies != exp_replies
					|| (tx_idle && tx !== 1'b1))) begin
				$display("CHECK FAILED at %0t: tx %b overrun %b replies %0d, expected %s",
					$time, tx, overrun, replies, "steady outputs");
				tb_errors++;
				reported = 1;
			end
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (total_errors() == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: failed", name);
	endtask

	initial begin
		int errs;
		int base;
		logic [OPERAND_W-1:0] op;
		clk = 1'b0;
		reset = 1'b1;
		rx = 1'b1;
		allow_overrun = 1'b0;
		tb_errors = 0;
		seed = 32'h9cce_6c8c;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		errs = total_errors();
		watch_outputs(200, 0, 1'b0, 1'b1);
		finish_test("reset idle", errs);

		// zero, the breakpoints with both signs, the extremes, just below each breakpoint
		errs = total_errors();
		run_frame(16'h0000);
		run_frame(16'h0800);
		run_frame(16'hf800);
		run_frame(16'h1300);
		run_frame(16'hed00);
		run_frame(16'h2800);
		run_frame(16'hd800);
		run_frame(16'h7fff);
		run_frame(16'h8000);
		run_frame(16'h07ff);
		run_frame(16'h12ff);
		run_frame(16'h27ff);
		run_frame(16'hf801);
		run_frame(16'hed01);
		run_frame(16'hd801);
		run_frame(16'hffff);
		finish_test("segment corners", errs);

		errs = total_errors();
		run_frame(16'h0a3c);
		finish_test("byte order", errs);

		errs = total_errors();
		repeat (NUM_RANDOM) begin
			op = 16'($random(seed));
			run_frame(op);
		end
		finish_test("random frames", errs);

		// lone byte with a low stop bit, then idle line
		errs = total_errors();
		base = replies;
		send_byte(8'h5a, 1'b0);
		drive_bit(1'b1);
		drive_bit(1'b1);
		run_frame(16'h1c2d);
		watch_outputs(600, base + 1, 1'b0, 1'b0);
		finish_test("bad stop bit", errs);

		// second frame lands while the first reply is still going out
		errs = total_errors();
		allow_overrun = 1'b1;
		base = replies;
		send_frame(16'h0400, 1'b1);
		send_frame(16'hfc00, 1'b0);
		wait_replies(base + 1, 16'h0400);
		watch_outputs(600, base + 1, 1'b1, 1'b0);
		finish_test("overrun", errs);

		if (pending != 0) begin
			$display("%0d expected replies never arrived", pending);
			tb_errors++;
		end
		$display("replies checked: %0d, failures: %0d", replies, total_errors());
		if (total_errors() == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
